/* rtl/dma_pkg.sv */
package dma_pkg;

    // bus widths
    localparam int ADDR_WD      = 32;
    localparam int DATA_WD      = 32;

    // bytes per full-width beat and its log2
    localparam int BEAT_BYTES   = DATA_WD / 8;
    localparam int BEAT_SHIFT   = $clog2(BEAT_BYTES);

    // command length in bytes, up to 1024
    localparam int LEN_WD       = 11;

    // axi burst length field
    localparam int AXLEN_WD     = 8;

    // local sram word address, 256 beats max
    localparam int SRAM_ADDR_WD = 8;

    // axi size code for a full-width beat
    localparam logic [2:0] AXSIZE_FULL = 3'(BEAT_SHIFT);

    // axi burst type code
    localparam logic [1:0] BURST_INCR  = 2'b01;

endpackage

/* rtl/dma_cmd_stage.sv */
`timescale 1ns/1ps

module dma_cmd_stage
    import dma_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  logic                cmd_rw,
    input  logic [ADDR_WD-1:0]  cmd_src_addr,
    input  logic [ADDR_WD-1:0]  cmd_dst_addr,
    input  logic [LEN_WD-1:0]   cmd_len,
    input  logic                rd_done,
    input  logic                wr_done,
    output logic                cmd_ready,
    output logic                dma_done,
    output logic                rd_start,
    output logic                wr_start,
    output logic [ADDR_WD-1:0]  src_addr,
    output logic [ADDR_WD-1:0]  dst_addr,
    output logic [AXLEN_WD-1:0] axlen
);

    logic              cmd_fire;
    logic [LEN_WD-1:0] beats;
    logic [LEN_WD-1:0] beats_m1;

    assign cmd_fire = cmd_valid && cmd_ready;

    // bytes to beats, then to the axi burst length
    assign beats    = cmd_len >> BEAT_SHIFT;
    assign beats_m1 = beats - 1'b1;

    // only one engine runs at a time
    assign dma_done = rd_done || wr_done;

    // busy from acceptance until an engine finishes
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_ready <= 1'b1;
        end else if (cmd_fire) begin
            cmd_ready <= 1'b0;
        end else if (dma_done) begin
            cmd_ready <= 1'b1;
        end
    end

    // start pulse for the selected direction
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= cmd_fire && !cmd_rw;
            wr_start <= cmd_fire && cmd_rw;
        end
    end

    // command payload, held for the whole transfer
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            src_addr <= cmd_src_addr;
            dst_addr <= cmd_dst_addr;
            axlen    <= beats_m1[AXLEN_WD-1:0];
        end
    end

endmodule

/* rtl/dma_read_engine.sv */
`timescale 1ns/1ps

module dma_read_engine
    import dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rd_start,
    input  logic [ADDR_WD-1:0]      src_addr,
    input  logic [AXLEN_WD-1:0]     axlen,
    input  logic                    arready,
    input  logic                    rvalid,
    input  logic [DATA_WD-1:0]      rdata,
    input  logic                    rlast,
    output logic                    arvalid,
    output logic [ADDR_WD-1:0]      araddr,
    output logic [AXLEN_WD-1:0]     arlen,
    output logic                    rready,
    output logic                    sram_we,
    output logic [SRAM_ADDR_WD-1:0] sram_waddr,
    output logic [DATA_WD-1:0]      sram_wdata,
    output logic                    rd_done
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    rd_state_t               state;
    logic                    ar_fire;
    logic                    r_fire;
    logic [SRAM_ADDR_WD-1:0] beat_cnt;

    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (rd_start) state <= RD_ADDR;
                RD_ADDR: if (ar_fire) state <= RD_DATA;
                // rready drops after the last beat
                RD_DATA: if (r_fire && rlast) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    // request held stable until arready
    always_ff @(posedge clk) begin
        if (rd_start) begin
            araddr <= src_addr;
            arlen  <= axlen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (rd_start) begin
            beat_cnt <= '0;
        end else if (r_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // sram write stage, one cycle behind each accepted beat
    always_ff @(posedge clk) begin
        if (rst) begin
            sram_we <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            sram_we <= r_fire;
            rd_done <= r_fire && rlast;
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            sram_waddr <= beat_cnt;
            sram_wdata <= rdata;
        end
    end

endmodule

/* rtl/dma_write_engine.sv */
`timescale 1ns/1ps

module dma_write_engine
    import dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_start,
    input  logic [ADDR_WD-1:0]      dst_addr,
    input  logic [AXLEN_WD-1:0]     axlen,
    input  logic                    awready,
    input  logic                    wready,
    input  logic                    bvalid,
    input  logic [DATA_WD-1:0]      sram_rdata,
    output logic                    awvalid,
    output logic [ADDR_WD-1:0]      awaddr,
    output logic [AXLEN_WD-1:0]     awlen,
    output logic                    wvalid,
    output logic [DATA_WD-1:0]      wdata,
    output logic                    wlast,
    output logic                    bready,
    output logic [SRAM_ADDR_WD-1:0] sram_raddr,
    output logic                    wr_done
);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_FETCH,
        WR_SEND,
        WR_RESP
    } wr_state_t;

    wr_state_t state;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;
    logic      last_beat;

    assign awvalid = (state == WR_ADDR);
    assign wvalid  = (state == WR_SEND);
    assign bready  = (state == WR_RESP);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // sram read address doubles as the beat count
    assign last_beat = (sram_raddr == awlen);
    assign wlast     = wvalid && last_beat;

    // sram output is stable while the read address is held
    assign wdata = sram_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_start) state <= WR_ADDR;
                end
                WR_ADDR: begin
                    // word 0 was requested on entry, so it is ready by now
                    if (aw_fire) state <= WR_SEND;
                end
                WR_FETCH: begin
                    // one cycle of sram read latency
                    state <= WR_SEND;
                end
                WR_SEND: begin
                    if (w_fire) begin
                        state <= last_beat ? WR_RESP : WR_FETCH;
                    end
                end
                WR_RESP: begin
                    if (b_fire) state <= WR_IDLE;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // write request held until awready
    always_ff @(posedge clk) begin
        if (wr_start) begin
            awaddr <= dst_addr;
            awlen  <= axlen;
        end
    end

    // fetch stage, next word requested after each accepted beat
    always_ff @(posedge clk) begin
        if (rst) begin
            sram_raddr <= '0;
        end else if (wr_start) begin
            sram_raddr <= '0;
        end else if (w_fire && !last_beat) begin
            sram_raddr <= sram_raddr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_done <= 1'b0;
        end else begin
            wr_done <= b_fire;
        end
    end

endmodule

/* rtl/axi_dma_top.sv */
`timescale 1ns/1ps

module axi_dma_top
    import dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    // command port
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  logic                    cmd_rw,
    input  logic [ADDR_WD-1:0]      cmd_src_addr,
    input  logic [ADDR_WD-1:0]      cmd_dst_addr,
    input  logic [LEN_WD-1:0]       cmd_len,
    output logic                    dma_done,
    // read address
    output logic                    M_AXI_ARVALID,
    output logic [ADDR_WD-1:0]      M_AXI_ARADDR,
    output logic [AXLEN_WD-1:0]     M_AXI_ARLEN,
    output logic [2:0]              M_AXI_ARSIZE,
    output logic [1:0]              M_AXI_ARBURST,
    input  logic                    M_AXI_ARREADY,
    // read data
    input  logic                    M_AXI_RVALID,
    input  logic [DATA_WD-1:0]      M_AXI_RDATA,
    input  logic                    M_AXI_RLAST,
    output logic                    M_AXI_RREADY,
    // write address
    output logic                    M_AXI_AWVALID,
    output logic [ADDR_WD-1:0]      M_AXI_AWADDR,
    output logic [AXLEN_WD-1:0]     M_AXI_AWLEN,
    output logic [2:0]              M_AXI_AWSIZE,
    output logic [1:0]              M_AXI_AWBURST,
    input  logic                    M_AXI_AWREADY,
    // write data
    output logic                    M_AXI_WVALID,
    output logic [DATA_WD-1:0]      M_AXI_WDATA,
    output logic [BEAT_BYTES-1:0]   M_AXI_WSTRB,
    output logic                    M_AXI_WLAST,
    input  logic                    M_AXI_WREADY,
    // write response
    input  logic                    M_AXI_BVALID,
    output logic                    M_AXI_BREADY,
    // local sram
    output logic                    sram_we,
    output logic [SRAM_ADDR_WD-1:0] sram_waddr,
    output logic [DATA_WD-1:0]      sram_wdata,
    output logic [SRAM_ADDR_WD-1:0] sram_raddr,
    input  logic [DATA_WD-1:0]      sram_rdata
);

    logic                rd_start;
    logic                wr_start;
    logic                rd_done;
    logic                wr_done;
    logic [ADDR_WD-1:0]  src_addr;
    logic [ADDR_WD-1:0]  dst_addr;
    logic [AXLEN_WD-1:0] axlen;

    // full-width incr bursts only
    assign M_AXI_ARSIZE  = AXSIZE_FULL;
    assign M_AXI_ARBURST = BURST_INCR;
    assign M_AXI_AWSIZE  = AXSIZE_FULL;
    assign M_AXI_AWBURST = BURST_INCR;
    assign M_AXI_WSTRB   = '1;

    dma_cmd_stage u_cmd_stage (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_rw       (cmd_rw),
        .cmd_src_addr (cmd_src_addr),
        .cmd_dst_addr (cmd_dst_addr),
        .cmd_len      (cmd_len),
        .rd_done      (rd_done),
        .wr_done      (wr_done),
        .cmd_ready    (cmd_ready),
        .dma_done     (dma_done),
        .rd_start     (rd_start),
        .wr_start     (wr_start),
        .src_addr     (src_addr),
        .dst_addr     (dst_addr),
        .axlen        (axlen)
    );

    dma_read_engine u_read_engine (
        .clk        (clk),
        .rst        (rst),
        .rd_start   (rd_start),
        .src_addr   (src_addr),
        .axlen      (axlen),
        .arready    (M_AXI_ARREADY),
        .rvalid     (M_AXI_RVALID),
        .rdata      (M_AXI_RDATA),
        .rlast      (M_AXI_RLAST),
        .arvalid    (M_AXI_ARVALID),
        .araddr     (M_AXI_ARADDR),
        .arlen      (M_AXI_ARLEN),
        .rready     (M_AXI_RREADY),
        .sram_we    (sram_we),
        .sram_waddr (sram_waddr),
        .sram_wdata (sram_wdata),
        .rd_done    (rd_done)
    );

    dma_write_engine u_write_engine (
        .clk        (clk),
        .rst        (rst),
        .wr_start   (wr_start),
        .dst_addr   (dst_addr),
        .axlen      (axlen),
        .awready    (M_AXI_AWREADY),
        .wready     (M_AXI_WREADY),
        .bvalid     (M_AXI_BVALID),
        .sram_rdata (sram_rdata),
        .awvalid    (M_AXI_AWVALID),
        .awaddr     (M_AXI_AWADDR),
        .awlen      (M_AXI_AWLEN),
        .wvalid     (M_AXI_WVALID),
        .wdata      (M_AXI_WDATA),
        .wlast      (M_AXI_WLAST),
        .bready     (M_AXI_BREADY),
        .sram_raddr (sram_raddr),
        .wr_done    (wr_done)
    );

endmodule

/* verif/dma_checker.sv */
`timescale 1ns/1ps

module dma_checker
    import dma_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic               cmd_valid,
    input logic               cmd_ready,
    input logic               cmd_rw,
    input logic               dma_done,
    input logic               arvalid,
    input logic               arready,
    input logic [ADDR_WD-1:0] araddr,
    input logic               awvalid,
    input logic               awready,
    input logic [ADDR_WD-1:0] awaddr,
    input logic               wvalid,
    input logic               wready,
    input logic [DATA_WD-1:0] wdata,
    input logic               wlast,
    input logic               sram_we
);

    logic rd_run;

    // read transfer in flight, from acceptance to dma_done
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_run <= 1'b0;
        end else if (cmd_valid && cmd_ready && !cmd_rw) begin
            rd_run <= 1'b1;
        end else if (dma_done) begin
            rd_run <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr changed before awready");

    // stalled w beat keeps its data and last flag
    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("wvalid dropped or w payload changed before wready");

    sram_we_in_read: assert property (@(posedge clk) disable iff (rst)
        sram_we |-> rd_run)
        else $error("sram write outside a read transfer");

    done_while_busy: assert property (@(posedge clk) disable iff (rst)
        dma_done |-> !cmd_ready)
        else $error("dma_done while cmd_ready is high");

endmodule

bind axi_dma_top dma_checker u_dma_checker (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_rw    (cmd_rw),
    .dma_done  (dma_done),
    .arvalid   (M_AXI_ARVALID),
    .arready   (M_AXI_ARREADY),
    .araddr    (M_AXI_ARADDR),
    .awvalid   (M_AXI_AWVALID),
    .awready   (M_AXI_AWREADY),
    .awaddr    (M_AXI_AWADDR),
    .wvalid    (M_AXI_WVALID),
    .wready    (M_AXI_WREADY),
    .wdata     (M_AXI_WDATA),
    .wlast     (M_AXI_WLAST),
    .sram_we   (sram_we)
);

/* verif/tb_axi_dma.sv */
`timescale 1ns/1ps

module tb_axi_dma;

    localparam int MEM_WORDS      = 4096;
    localparam int SRAM_WORDS     = 256;
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk = 1'b0;
    logic        rst;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        cmd_rw;
    logic [31:0] cmd_src_addr;
    logic [31:0] cmd_dst_addr;
    logic [10:0] cmd_len;
    logic        dma_done;

    logic        M_AXI_ARVALID;
    logic [31:0] M_AXI_ARADDR;
    logic [7:0]  M_AXI_ARLEN;
    logic [2:0]  M_AXI_ARSIZE;
    logic [1:0]  M_AXI_ARBURST;
    logic        M_AXI_ARREADY = 1'b0;
    logic        M_AXI_RVALID  = 1'b0;
    logic [31:0] M_AXI_RDATA   = '0;
    logic        M_AXI_RLAST   = 1'b0;
    logic        M_AXI_RREADY;
    logic        M_AXI_AWVALID;
    logic [31:0] M_AXI_AWADDR;
    logic [7:0]  M_AXI_AWLEN;
    logic [2:0]  M_AXI_AWSIZE;
    logic [1:0]  M_AXI_AWBURST;
    logic        M_AXI_AWREADY = 1'b0;
    logic        M_AXI_WVALID;
    logic [31:0] M_AXI_WDATA;
    logic [3:0]  M_AXI_WSTRB;
    logic        M_AXI_WLAST;
    logic        M_AXI_WREADY  = 1'b0;
    logic        M_AXI_BVALID  = 1'b0;
    logic        M_AXI_BREADY;

    logic        sram_we;
    logic [7:0]  sram_waddr;
    logic [31:0] sram_wdata;
    logic [7:0]  sram_raddr;
    logic [31:0] sram_rdata    = '0;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] sram [SRAM_WORDS];
    logic [31:0] exp_words [SRAM_WORDS];

    int          seed = 32'h3489;
    logic        stall_en;
    string       cur_test = "init";

    // slave and monitor state
    int          cyc = 0;
    int          done_cnt = 0;
    int          done_cyc;
    int          rlast_cyc;
    int          b_cyc;
    int          sram_wr_cnt = 0;
    int          rd_left = 0;
    int          w_cnt = 0;
    logic [31:0] rd_addr = '0;
    logic [31:0] wr_addr = '0;
    logic [31:0] ar_addr_seen;
    logic [31:0] aw_addr_seen;
    int          ar_len_seen;
    int          aw_len_seen;
    logic [7:0]  raddr_s;
    logic        ar_hs;
    logic        r_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        b_hs;
    logic        b_due;

    axi_dma_top DUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'ha5c3_0f1e;
    endfunction

    function automatic logic draw_ready();
        if (!stall_en) begin
            return 1'b1;
        end
        return ($random(seed) & 3) != 0;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("FAILED %s %s: expected %h, actual %h",
                                     cur_test, what, expected, actual));
        end
    endtask

    // slave, sram and monitor: sample at the edge, drive 2 ns later
    always @(posedge clk) begin
        cyc   = cyc + 1;
        ar_hs = M_AXI_ARVALID && M_AXI_ARREADY;
        r_hs  = M_AXI_RVALID && M_AXI_RREADY;
        aw_hs = M_AXI_AWVALID && M_AXI_AWREADY;
        w_hs  = M_AXI_WVALID && M_AXI_WREADY;
        b_hs  = M_AXI_BVALID && M_AXI_BREADY;
        b_due = 1'b0;
        if (dma_done) begin
            done_cnt = done_cnt + 1;
            done_cyc = cyc;
        end
        if (sram_we) begin
            check_value("sram_waddr", sram_wr_cnt, sram_waddr);
            sram[sram_waddr] = sram_wdata;
            sram_wr_cnt = sram_wr_cnt + 1;
        end
        raddr_s = sram_raddr;
        if (ar_hs) begin
            // 4-byte beats in an incr burst
            check_value("arsize", 3'd2, M_AXI_ARSIZE);
            check_value("arburst", 2'b01, M_AXI_ARBURST);
            rd_addr      = M_AXI_ARADDR;
            rd_left      = int'(M_AXI_ARLEN) + 1;
            ar_addr_seen = M_AXI_ARADDR;
            ar_len_seen  = int'(M_AXI_ARLEN);
        end
        if (r_hs) begin
            rd_addr = rd_addr + 4;
            rd_left = rd_left - 1;
            if (M_AXI_RLAST) begin
                rlast_cyc = cyc;
            end
        end
        if (aw_hs) begin
            check_value("awsize", 3'd2, M_AXI_AWSIZE);
            check_value("awburst", 2'b01, M_AXI_AWBURST);
            wr_addr      = M_AXI_AWADDR;
            aw_addr_seen = M_AXI_AWADDR;
            aw_len_seen  = int'(M_AXI_AWLEN);
            w_cnt        = 0;
        end
        if (w_hs) begin
            check_value("wlast", w_cnt == aw_len_seen, M_AXI_WLAST);
            check_value("wstrb", 4'hf, M_AXI_WSTRB);
            mem[wr_addr[13:2]] = M_AXI_WDATA;
            wr_addr = wr_addr + 4;
            w_cnt   = w_cnt + 1;
            b_due   = M_AXI_WLAST;
        end
        if (b_hs) begin
            b_cyc = cyc;
        end
        #2;
        sram_rdata    = sram[raddr_s];
        M_AXI_ARREADY = draw_ready();
        M_AXI_AWREADY = draw_ready();
        M_AXI_WREADY  = draw_ready();
        // rvalid stays up until its handshake
        if (!M_AXI_RVALID || r_hs) begin
            M_AXI_RVALID = (rd_left != 0) && draw_ready();
        end
        M_AXI_RDATA = mem[rd_addr[13:2]];
        M_AXI_RLAST = (rd_left == 1);
        if (b_hs) begin
            M_AXI_BVALID = 1'b0;
        end
        if (b_due) begin
            M_AXI_BVALID = 1'b1;
        end
    end

    task automatic drive_cmd(input logic rw, input logic [31:0] src,
                             input logic [31:0] dst, input int len);
        cmd_valid    = 1'b1;
        cmd_rw       = rw;
        cmd_src_addr = src;
        cmd_dst_addr = dst;
        cmd_len      = 11'(len);
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                report_failure({"timeout in ", cur_test, ": command never accepted"});
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic send_cmd(input logic rw, input logic [31:0] src,
                            input logic [31:0] dst, input int len);
        @(posedge clk);
        #2;
        drive_cmd(rw, src, dst, len);
        wait_accept();
    endtask

    task automatic wait_done(input int base);
        int n;
        n = 0;
        @(negedge clk);
        while (done_cnt == base) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                report_failure({"timeout in ", cur_test, ": dma_done never came"});
            end
            @(negedge clk);
        end
    endtask

    // no extra dma_done, channels quiet and the DUT is ready again
    task automatic check_idle(input int exp_done);
        repeat (3) @(negedge clk);
        check_value("dma_done count", exp_done, done_cnt);
        check_value("cmd_ready idle", 1'b1, cmd_ready);
        check_value("arvalid idle", 1'b0, M_AXI_ARVALID);
        check_value("rready idle", 1'b0, M_AXI_RREADY);
        check_value("awvalid idle", 1'b0, M_AXI_AWVALID);
        check_value("wvalid idle", 1'b0, M_AXI_WVALID);
        check_value("bready idle", 1'b0, M_AXI_BREADY);
    endtask

    task automatic test_reset();
        cur_test = "reset";
        @(negedge clk);
        check_value("cmd_ready", 1'b1, cmd_ready);
        check_value("arvalid", 1'b0, M_AXI_ARVALID);
        check_value("rready", 1'b0, M_AXI_RREADY);
        check_value("awvalid", 1'b0, M_AXI_AWVALID);
        check_value("wvalid", 1'b0, M_AXI_WVALID);
        check_value("bready", 1'b0, M_AXI_BREADY);
        check_value("sram_we", 1'b0, sram_we);
        check_value("dma_done", 1'b0, dma_done);
    endtask

    task automatic run_read(input string name, input logic [31:0] src, input int len);
        int beats;
        int base;
        beats    = len / 4;
        base     = done_cnt;
        cur_test = name;
        for (int k = 0; k < SRAM_WORDS; k++) begin
            sram[k] = '0;
        end
        sram_wr_cnt = 0;
        send_cmd(1'b0, src, 32'h0, len);
        wait_done(base);
        check_value("araddr", src, ar_addr_seen);
        check_value("arlen", beats - 1, ar_len_seen);
        check_value("sram writes", beats, sram_wr_cnt);
        check_value("done after rlast", rlast_cyc + 1, done_cyc);
        for (int k = 0; k < beats; k++) begin
            check_value($sformatf("sram word %0d", k), fill_word(src + 32'(4 * k)), sram[k]);
        end
        check_idle(base + 1);
    endtask

    task automatic run_write(input string name, input logic [31:0] dst, input int len);
        int beats;
        int base;
        beats    = len / 4;
        base     = done_cnt;
        cur_test = name;
        for (int k = 0; k < beats; k++) begin
            exp_words[k] = $random(seed);
            sram[k]      = exp_words[k];
        end
        send_cmd(1'b1, 32'h0, dst, len);
        wait_done(base);
        check_value("awaddr", dst, aw_addr_seen);
        check_value("awlen", beats - 1, aw_len_seen);
        check_value("w beats", beats, w_cnt);
        check_value("done after bresp", b_cyc + 1, done_cyc);
        for (int k = 0; k < beats; k++) begin
            check_value($sformatf("mem word %0d", k), exp_words[k], mem[dst[13:2] + 12'(k)]);
        end
        check_idle(base + 1);
    endtask

    // write command held while a read runs, then sends the words just read
    task automatic test_busy();
        int base;
        int n;
        base     = done_cnt;
        cur_test = "busy";
        sram_wr_cnt = 0;
        send_cmd(1'b0, 32'h0800, 32'h0, 32);
        @(posedge clk);
        #2;
        drive_cmd(1'b1, 32'h0, 32'h3800, 32);
        n = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            n++;
            if (n > TIMEOUT_CYCLES) begin
                report_failure("timeout in busy: second command never accepted");
            end
            @(negedge clk);
        end
        check_value("taken after dma_done", base + 1, done_cnt);
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
        wait_done(base + 1);
        check_value("done after bresp", b_cyc + 1, done_cyc);
        for (int k = 0; k < 8; k++) begin
            check_value($sformatf("mem word %0d", k), fill_word(32'h0800 + 32'(4 * k)),
                        mem[12'h0e00 + 12'(k)]);
        end
        check_idle(base + 2);
    endtask

    initial begin
        rst          = 1'b1;
        stall_en     = 1'b0;
        cmd_valid    = 1'b0;
        cmd_rw       = 1'b0;
        cmd_src_addr = '0;
        cmd_dst_addr = '0;
        cmd_len      = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(32'(i) << 2);
        end
        for (int i = 0; i < SRAM_WORDS; i++) begin
            sram[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        test_reset();
        run_read("read_64", 32'h1040, 64);
        run_write("write_32", 32'h2000, 32);

        // random ready and valid stalls from here on
        stall_en = 1'b1;
        run_read("read_4_stall", 32'h1100, 4);
        run_read("read_1024_stall", 32'h1000, 1024);
        run_write("write_4_stall", 32'h2400, 4);
        run_write("write_1024_stall", 32'h2800, 1024);
        test_busy();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* all.f */
rtl/dma_pkg.sv
rtl/dma_cmd_stage.sv
rtl/dma_read_engine.sv
rtl/dma_write_engine.sv
rtl/axi_dma_top.sv
verif/dma_checker.sv
verif/tb_axi_dma.sv

/* run.sh */
#!/bin/sh
# build and run the DMA testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_dma \
    -f all.f \
    -o sim_tb_axi_dma

./obj_dir/sim_tb_axi_dma 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

# an assertion stop leaves no pass line behind
grep -q "Simulation completed successfully" sim.log
